// ==== source/building_pkg.sv ====
// Building geometry for one car; floor 0 is the ground floor, and masks are LSB first
`default_nettype none

package building_pkg;

    ////////////////////
    // Floor geometry
    ////////////////////

    // Floors served by the car
    localparam int NUM_FLOORS = 11;

    // Wide enough to index every floor
    localparam int FLOOR_W = 4;

    ////////////////////
    // Floor types
    ////////////////////

    // Floor index, 0 up to NUM_FLOORS-1
    typedef logic [FLOOR_W-1:0] floor_t;

    // One bit per floor for requests and lights
    typedef logic [NUM_FLOORS-1:0] floor_mask_t;

endpackage

`default_nettype wire

// ==== source/car_pkg.sv ====
// Car states and timing in clock cycles; each timing constant must fit in TIMER_W bits
`default_nettype none

package car_pkg;

    ////////////////////
    // Car states
    ////////////////////

    typedef enum logic [2:0] {
        CAR_IDLE      = 3'd0,
        CAR_MOVE_UP   = 3'd1,
        CAR_MOVE_DOWN = 3'd2,
        CAR_DOOR_OPEN = 3'd3,
        CAR_HALT      = 3'd4
    } car_state_e;

    ////////////////////
    // Timing
    ////////////////////

    // Floor to floor travel
    localparam int TRAVEL_CYCLES = 8;
    // Door dwell at a stop
    localparam int DOOR_CYCLES = 6;

    localparam int TIMER_W = 4;
    typedef logic [TIMER_W-1:0] timer_count_t;

endpackage

`default_nettype wire

// ==== source/request_register.sv ====
// Requests stay latched until the car arrives at their floor; power off clears all of them
`default_nettype none

module request_register
    import building_pkg::*;
(
    input  logic        clock,
    input  logic        reset_n,
    input  logic        power_switch,
    input  floor_mask_t hall_call_buttons,
    input  floor_mask_t panel_buttons,
    input  floor_t      current_floor,
    input  logic        arrive,
    output floor_mask_t hall_requests,
    output floor_mask_t panel_requests
);

    floor_mask_t clear_mask;
    floor_mask_t hall_next;
    floor_mask_t panel_next;

    ////////////////////
    // Next request state
    ////////////////////

    always_comb begin
        // Served floor only, and only in the arrival cycle
        if (arrive) begin
            clear_mask = floor_mask_t'(1) << current_floor;
        end else begin
            clear_mask = '0;
        end

        // A press at the served floor during arrival is absorbed
        hall_next  = (hall_requests | hall_call_buttons) & ~clear_mask;
        panel_next = (panel_requests | panel_buttons) & ~clear_mask;
    end

    ////////////////////
    // Request bits
    ////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            hall_requests  <= '0;
            panel_requests <= '0;
        end else if (!power_switch) begin
            // Power loss drops every call and every light
            hall_requests  <= '0;
            panel_requests <= '0;
        end else begin
            hall_requests  <= hall_next;
            panel_requests <= panel_next;
        end
    end

endmodule

`default_nettype wire

// ==== source/target_selector.sv ====
// Combinational; panel requests mask hall calls entirely while any panel request is pending
`default_nettype none

module target_selector
    import building_pkg::*;
(
    input  floor_mask_t hall_requests,
    input  floor_mask_t panel_requests,
    input  floor_t      current_floor,
    input  logic        direction_up,
    output floor_t      target_floor,
    output logic        target_valid
);

    floor_mask_t pick_mask;
    logic        above_found;
    floor_t      above_floor;
    logic        below_found;
    floor_t      below_floor;

    // Panel first, hall calls only when the panel is empty
    assign pick_mask    = (|panel_requests) ? panel_requests : hall_requests;
    assign target_valid = |pick_mask;

    ////////////////////
    // Nearest at or above
    ////////////////////

    // Walk downward so the lowest match is the one kept
    always_comb begin
        above_found = 1'b0;
        above_floor = '0;
        for (int i = NUM_FLOORS - 1; i >= 0; i--) begin
            if (pick_mask[i] && (i >= int'(current_floor))) begin
                above_found = 1'b1;
                above_floor = floor_t'(i);
            end
        end
    end

    ////////////////////
    // Nearest at or below
    ////////////////////

    // Walk upward so the highest match is the one kept
    always_comb begin
        below_found = 1'b0;
        below_floor = '0;
        for (int i = 0; i < NUM_FLOORS; i++) begin
            if (pick_mask[i] && (i <= int'(current_floor))) begin
                below_found = 1'b1;
                below_floor = floor_t'(i);
            end
        end
    end

    ////////////////////
    // Direction preference
    ////////////////////

    // Keep going the same way, turn around only when nothing is ahead
    always_comb begin
        if (direction_up) begin
            target_floor = above_found ? above_floor : below_floor;
        end else begin
            target_floor = below_found ? below_floor : above_floor;
        end
    end

endmodule

`default_nettype wire

// ==== source/car_motion_fsm.sv ====
// Target is committed when the car leaves rest; power off beats emergency, which beats buttons
`default_nettype none

module car_motion_fsm
    import building_pkg::*;
    import car_pkg::*;
(
    input  logic   clock,
    input  logic   reset_n,
    input  logic   power_switch,
    input  logic   emergency_btn,
    input  logic   door_open_btn,
    input  logic   door_close_btn,
    input  floor_t target_floor,
    input  logic   target_valid,
    input  logic   expired,
    output floor_t current_floor,
    output logic   direction_up,
    output logic   moving,
    output logic   door_open,
    output logic   arrive,
    output logic   load_travel,
    output logic   load_door,
    output logic   hold
);

    car_state_e state;
    car_state_e state_next;
    car_state_e saved_state;
    floor_t     target_q;
    floor_t     target_next;
    floor_t     floor_next;
    logic       dir_next;
    logic       arrive_next;

    assign moving    = (state == CAR_MOVE_UP) || (state == CAR_MOVE_DOWN);
    assign door_open = (state == CAR_DOOR_OPEN);
    // Freeze the timer already in the cycle emergency shows up, so no expiry is lost
    assign hold = (state == CAR_HALT) || emergency_btn;

    ////////////////////
    // Next state
    ////////////////////

    always_comb begin
        state_next  = state;
        floor_next  = current_floor;
        dir_next    = direction_up;
        target_next = target_q;
        arrive_next = 1'b0;
        load_travel = 1'b0;
        load_door   = 1'b0;

        if (!power_switch) begin
            state_next = CAR_IDLE;
        end else if (emergency_btn) begin
            state_next = CAR_HALT;
        end else begin
            case (state)
                CAR_IDLE: begin
                    if (door_open_btn) begin
                        state_next = CAR_DOOR_OPEN;
                        load_door  = 1'b1;
                    end else if (target_valid) begin
                        target_next = target_floor;
                        if (target_floor == current_floor) begin
                            state_next  = CAR_DOOR_OPEN;
                            arrive_next = 1'b1;
                            load_door   = 1'b1;
                        end else begin
                            load_travel = 1'b1;
                            dir_next    = (target_floor > current_floor);
                            state_next  = (target_floor > current_floor) ? CAR_MOVE_UP
                                                                         : CAR_MOVE_DOWN;
                        end
                    end
                end
                CAR_MOVE_UP, CAR_MOVE_DOWN: begin
                    // One floor per timer expiry
                    if (expired) begin
                        if (state == CAR_MOVE_UP) begin
                            floor_next = current_floor + 1'b1;
                        end else begin
                            floor_next = current_floor - 1'b1;
                        end
                        if (floor_next == target_q) begin
                            state_next  = CAR_DOOR_OPEN;
                            arrive_next = 1'b1;
                            load_door   = 1'b1;
                        end else begin
                            load_travel = 1'b1;
                        end
                    end
                end
                CAR_DOOR_OPEN: begin
                    // Open button wins over close
                    if (door_open_btn) begin
                        load_door = 1'b1;
                    end else if (door_close_btn || expired) begin
                        state_next = CAR_IDLE;
                    end
                end
                CAR_HALT: begin
                    state_next = saved_state;
                end
                default: begin
                    state_next = CAR_IDLE;
                end
            endcase
        end
    end

    ////////////////////
    // Control registers
    ////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state         <= CAR_IDLE;
            saved_state   <= CAR_IDLE;
            current_floor <= '0;
            direction_up  <= 1'b0;
            arrive        <= 1'b0;
        end else begin
            state         <= state_next;
            current_floor <= floor_next;
            direction_up  <= dir_next;
            arrive        <= arrive_next;
            // Only a move survives a halt; anything else resumes at rest
            if (state != CAR_HALT) begin
                saved_state <= moving ? state : CAR_IDLE;
            end
        end
    end

    // Committed target
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            target_q <= '0;
        end else begin
            target_q <= target_next;
        end
    end

endmodule

`default_nettype wire

// ==== source/travel_timer.sv ====
// Expiry is a single cycle pulse; a load restarts the count even when one is running
`default_nettype none

module travel_timer
    import car_pkg::*;
(
    input  logic clock,
    input  logic reset_n,
    input  logic load_travel,
    input  logic load_door,
    input  logic hold,
    output logic expired
);

    timer_count_t count;

    ////////////////////
    // Down counter
    ////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            count <= '0;
        end else if (load_travel) begin
            count <= timer_count_t'(TRAVEL_CYCLES);
        end else if (load_door) begin
            count <= timer_count_t'(DOOR_CYCLES);
        end else if (!hold && (count != '0)) begin
            count <= count - 1'b1;
        end
    end

    // High in the cycle whose edge takes the count to zero
    assign expired = !hold && (count == timer_count_t'(1));

endmodule

`default_nettype wire

// ==== source/elevator_controller.sv ====
// Single car controller; button inputs are synchronous levels, lights mirror pending requests
`default_nettype none

module elevator_controller
    import building_pkg::*;
(
    input  logic        clock,
    input  logic        reset_n,
    input  floor_mask_t hall_call_buttons,
    input  floor_mask_t panel_buttons,
    input  logic        door_open_btn,
    input  logic        door_close_btn,
    input  logic        emergency_btn,
    input  logic        power_switch,
    output floor_t      current_floor,
    output logic        moving,
    output logic        direction_up,
    output logic        door_open,
    output floor_mask_t call_button_lights,
    output floor_mask_t panel_button_lights
);

    floor_t target_floor;
    logic   target_valid;
    logic   arrive;
    logic   load_travel;
    logic   load_door;
    logic   hold;
    logic   expired;

    ////////////////////
    // Requests
    ////////////////////

    // Light outputs double as the request masks
    request_register u_request_register (
        .clock             (clock),
        .reset_n           (reset_n),
        .power_switch      (power_switch),
        .hall_call_buttons (hall_call_buttons),
        .panel_buttons     (panel_buttons),
        .current_floor     (current_floor),
        .arrive            (arrive),
        .hall_requests     (call_button_lights),
        .panel_requests    (panel_button_lights)
    );

    target_selector u_target_selector (
        .hall_requests  (call_button_lights),
        .panel_requests (panel_button_lights),
        .current_floor  (current_floor),
        .direction_up   (direction_up),
        .target_floor   (target_floor),
        .target_valid   (target_valid)
    );

    ////////////////////
    // Car motion
    ////////////////////

    car_motion_fsm u_car_motion_fsm (
        .clock          (clock),
        .reset_n        (reset_n),
        .power_switch   (power_switch),
        .emergency_btn  (emergency_btn),
        .door_open_btn  (door_open_btn),
        .door_close_btn (door_close_btn),
        .target_floor   (target_floor),
        .target_valid   (target_valid),
        .expired        (expired),
        .current_floor  (current_floor),
        .direction_up   (direction_up),
        .moving         (moving),
        .door_open      (door_open),
        .arrive         (arrive),
        .load_travel    (load_travel),
        .load_door      (load_door),
        .hold           (hold)
    );

    travel_timer u_travel_timer (
        .clock       (clock),
        .reset_n     (reset_n),
        .load_travel (load_travel),
        .load_door   (load_door),
        .hold        (hold),
        .expired     (expired)
    );

endmodule

`default_nettype wire

// ==== tests/elevator_checker.sv ====
// Safety rules of the car, checked only out of reset; each failure also counts up a tally
`default_nettype none

module elevator_checker
    import building_pkg::*;
(
    input logic        clock,
    input logic        reset_n,
    input logic        power_switch,
    input floor_t      current_floor,
    input logic        moving,
    input logic        door_open,
    input floor_mask_t call_button_lights,
    input floor_mask_t panel_button_lights
);

    timeunit 1ns;
    timeprecision 100ps;

    int unsigned assert_failures = 0;

    ////////////////////
    // Car safety
    ////////////////////

    door_vs_motion: assert property (@(posedge clock) disable iff (!reset_n)
        !(door_open && moving))
        else begin
            $error("Door open while the car is moving");
            assert_failures++;
        end

    // Floor changes come from a travel step only
    floor_step: assert property (@(posedge clock) disable iff (!reset_n)
        $changed(current_floor) |-> $past(moving) &&
            ((int'(current_floor) == int'($past(current_floor)) + 1) ||
             (int'(current_floor) == int'($past(current_floor)) - 1)))
        else begin
            $error("Floor jumped or changed while not moving");
            assert_failures++;
        end

    lights_off: assert property (@(posedge clock) disable iff (!reset_n)
        !power_switch |=> (call_button_lights == '0) && (panel_button_lights == '0))
        else begin
            $error("Lights still on one cycle after power off");
            assert_failures++;
        end

    floor_range: assert property (@(posedge clock) disable iff (!reset_n)
        int'(current_floor) < NUM_FLOORS)
        else begin
            $error("Floor index beyond the top floor");
            assert_failures++;
        end

endmodule

`default_nettype wire

// ==== tests/tb_elevator.sv ====
// Directed tests on one car; each test starts from where the previous one left the car
`default_nettype none

module tb_elevator
    import building_pkg::*;
    import car_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLOCK_HALF   = 5;
    localparam int RESET_CYCLES = 10;
    localparam int RANDOM_SEED  = 29;
    localparam int NUM_TESTS    = 6;
    // Worst case per test: several full-height trips plus a few door dwells
    localparam int TEST_BUDGET  = 4 * NUM_FLOORS * TRAVEL_CYCLES + 8 * DOOR_CYCLES + 100;

    logic        clock;
    logic        reset_n;
    floor_mask_t hall_call_buttons;
    floor_mask_t panel_buttons;
    logic        door_open_btn;
    logic        door_close_btn;
    logic        emergency_btn;
    logic        power_switch;
    floor_t      current_floor;
    logic        moving;
    logic        direction_up;
    logic        door_open;
    floor_mask_t call_button_lights;
    floor_mask_t panel_button_lights;
    string       test_name;

    elevator_controller u_dut (
        .clock               (clock),
        .reset_n             (reset_n),
        .hall_call_buttons   (hall_call_buttons),
        .panel_buttons       (panel_buttons),
        .door_open_btn       (door_open_btn),
        .door_close_btn      (door_close_btn),
        .emergency_btn       (emergency_btn),
        .power_switch        (power_switch),
        .current_floor       (current_floor),
        .moving              (moving),
        .direction_up        (direction_up),
        .door_open           (door_open),
        .call_button_lights  (call_button_lights),
        .panel_button_lights (panel_button_lights)
    );

    bind elevator_controller elevator_checker u_checker (
        .clock               (clock),
        .reset_n             (reset_n),
        .power_switch        (power_switch),
        .current_floor       (current_floor),
        .moving              (moving),
        .door_open           (door_open),
        .call_button_lights  (call_button_lights),
        .panel_button_lights (panel_button_lights)
    );

    initial begin
        clock = 1'b0;
        forever #CLOCK_HALF clock = ~clock;
    end

    initial begin
        repeat (NUM_TESTS * TEST_BUDGET) @(posedge clock);
        $display("Watchdog expired: the tests ran longer than %0d cycles",
                 NUM_TESTS * TEST_BUDGET);
        $display("=== FAIL ===");
        $fatal(1, "Run stopped by the watchdog");
    end

    initial begin
        wait (u_dut.u_checker.assert_failures != 0);
        $display("Safety assertion failed in the bound checker");
        $display("=== FAIL ===");
        $fatal(1, "Stopped at the first failed assertion");
    end

    ////////////////////
    // Helpers
    ////////////////////

    task automatic check(input string what, input int expected, input int actual);
        if (expected != actual) begin
            $display("CHECK FAILED %s %s: expected %0d, actual %0d",
                     test_name, what, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "Stopped at the first failed check");
        end
    endtask

    function automatic floor_mask_t floor_bit(input int index);
        floor_bit = floor_mask_t'(1) << index;
    endfunction

    // One cycle press, seen by the DUT at the second edge
    task automatic press_buttons(input floor_mask_t hall, input floor_mask_t panel);
        @(posedge clock);
        hall_call_buttons <= hall;
        panel_buttons     <= panel;
        @(posedge clock);
        hall_call_buttons <= '0;
        panel_buttons     <= '0;
    endtask

    task automatic wait_door(input logic level);
        @(negedge clock);
        while (door_open != level) begin
            @(negedge clock);
        end
    endtask

    task automatic wait_moving();
        @(negedge clock);
        while (!moving) begin
            @(negedge clock);
        end
    endtask

    // Cycles from the present negedge until the floor changes
    task automatic time_next_step(output int cycles);
        floor_t prev_floor;
        prev_floor = current_floor;
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
        end while (current_floor == prev_floor);
    endtask

    ////////////////////
    // Directed tests
    ////////////////////

    task automatic test_reset();
        test_name = "reset";
        @(negedge clock);
        check("floor", 0, int'(current_floor));
        check("moving", 0, int'(moving));
        check("door", 0, int'(door_open));
        check("call lights", 0, int'(call_button_lights));
        check("panel lights", 0, int'(panel_button_lights));
    endtask

    task automatic test_panel_request();
        int target;
        int cycles;
        test_name = "panel_request";
        // Kept low so the next test can still arrive at floor 5 going up
        target = 1 + int'($urandom % 4);
        press_buttons('0, floor_bit(target));
        @(negedge clock);
        check("light set", 1, int'(panel_button_lights[target]));
        check("at rest", 0, int'(moving));
        wait_moving();
        for (int f = 1; f <= target; f++) begin
            time_next_step(cycles);
            check("travel time", TRAVEL_CYCLES, cycles);
            check("floor step", f, int'(current_floor));
        end
        check("door at target", 1, int'(door_open));
        @(negedge clock);
        check("light cleared", 0, int'(panel_button_lights[target]));
        wait_door(1'b0);
    endtask

    task automatic test_priority();
        int order[3] = '{8, 2, 9};
        test_name = "priority";
        press_buttons('0, floor_bit(5));
        wait_door(1'b1);
        check("start floor", 5, int'(current_floor));
        check("heading up", 1, int'(direction_up));
        press_buttons(floor_bit(9), floor_bit(2) | floor_bit(8));
        // Panel ahead first, then panel behind, hall calls last
        foreach (order[i]) begin
            wait_door(1'b0);
            wait_door(1'b1);
            check("stop order", order[i], int'(current_floor));
        end
        wait_door(1'b0);
        check("call lights", 0, int'(call_button_lights));
        check("panel lights", 0, int'(panel_button_lights));
    endtask

    task automatic test_door_control();
        int here;
        int cycles;
        test_name = "door_control";
        here = int'(current_floor);
        press_buttons('0, floor_bit(here));
        do begin
            @(negedge clock);
            check("no motion", 0, int'(moving));
        end while (!door_open);
        check("same floor", here, int'(current_floor));
        @(posedge clock);
        door_close_btn <= 1'b1;
        @(posedge clock);
        door_close_btn <= 1'b0;
        @(negedge clock);
        check("closed early", 0, int'(door_open));
        check("light cleared", 0, int'(panel_button_lights[here]));
        // Open at rest and hold well past one dwell
        @(posedge clock);
        door_open_btn <= 1'b1;
        repeat (DOOR_CYCLES + 4) begin
            @(posedge clock);
            @(negedge clock);
            check("held open", 1, int'(door_open));
        end
        @(posedge clock);
        door_open_btn <= 1'b0;
        // Button is still seen high at this edge, so the dwell restarts here
        @(negedge clock);
        cycles = 0;
        while (door_open) begin
            @(negedge clock);
            cycles++;
        end
        check("dwell after release", DOOR_CYCLES, cycles);
    endtask

    task automatic test_emergency();
        int     target;
        int     cycles;
        floor_t halted_floor;
        test_name = "emergency";
        // At least two floors below the car, so the halt lands mid-trip
        target = int'($urandom % 8);
        press_buttons('0, floor_bit(target));
        wait_moving();
        time_next_step(cycles);
        repeat (3) @(negedge clock);
        @(posedge clock);
        emergency_btn <= 1'b1;
        @(posedge clock);
        @(negedge clock);
        check("halted", 0, int'(moving));
        halted_floor = current_floor;
        repeat (2 * TRAVEL_CYCLES) begin
            @(negedge clock);
            check("floor held", int'(halted_floor), int'(current_floor));
            check("still halted", 0, int'(moving));
        end
        @(posedge clock);
        emergency_btn <= 1'b0;
        wait_moving();
        // Four cycles of the trip were spent before the halt
        time_next_step(cycles);
        check("remaining travel", TRAVEL_CYCLES - 4, cycles);
        if (!door_open) begin
            wait_door(1'b1);
        end
        check("target reached", target, int'(current_floor));
        check("heading down", 0, int'(direction_up));
        wait_door(1'b0);
    endtask

    task automatic test_power_off();
        int          here;
        int          far;
        floor_mask_t hall;
        test_name = "power_off";
        here = int'(current_floor);
        far  = (here + 1 + int'($urandom % (NUM_FLOORS - 1))) % NUM_FLOORS;
        hall = floor_mask_t'($urandom) & ~floor_bit(here);
        @(posedge clock);
        hall_call_buttons <= hall;
        panel_buttons     <= floor_bit(far);
        @(posedge clock);
        hall_call_buttons <= '0;
        panel_buttons     <= '0;
        power_switch      <= 1'b0;
        @(negedge clock);
        check("call lights set", int'(hall), int'(call_button_lights));
        check("panel light set", int'(floor_bit(far)), int'(panel_button_lights));
        @(negedge clock);
        check("call lights off", 0, int'(call_button_lights));
        check("panel lights off", 0, int'(panel_button_lights));
        press_buttons(floor_bit(far), floor_bit(far));
        repeat (2 * TRAVEL_CYCLES) begin
            @(negedge clock);
            check("no motion", 0, int'(moving));
            check("floor kept", here, int'(current_floor));
            check("no requests", 0, int'(panel_button_lights | call_button_lights));
        end
        @(posedge clock);
        power_switch <= 1'b1;
        repeat (2 * TRAVEL_CYCLES) begin
            @(negedge clock);
            check("idle after power on", 0, int'(moving));
        end
        press_buttons('0, floor_bit(far));
        wait_door(1'b1);
        check("new request served", far, int'(current_floor));
        wait_door(1'b0);
    endtask

    ////////////////////
    // Sequence
    ////////////////////

    initial begin
        void'($urandom(RANDOM_SEED));
        reset_n           = 1'b0;
        hall_call_buttons = '0;
        panel_buttons     = '0;
        door_open_btn     = 1'b0;
        door_close_btn    = 1'b0;
        emergency_btn     = 1'b0;
        power_switch      = 1'b1;
        test_name         = "setup";
        repeat (RESET_CYCLES) @(posedge clock);
        reset_n <= 1'b1;

        test_reset();
        test_panel_request();
        test_priority();
        test_door_control();
        test_emergency();
        test_power_off();

        if (u_dut.u_checker.assert_failures == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("Safety assertions failed %0d times", u_dut.u_checker.assert_failures);
            $display("=== FAIL ===");
            $fatal(1, "Assertion failures in the bound checker");
        end
    end

endmodule

`default_nettype wire

// ==== tb.f ====
source/building_pkg.sv
source/car_pkg.sv
source/request_register.sv
source/target_selector.sv
source/car_motion_fsm.sv
source/travel_timer.sv
source/elevator_controller.sv
tests/elevator_checker.sv
tests/tb_elevator.sv

// ==== Makefile ====
# Verilator simulation of the elevator controller testbench

VERILATOR  ?= verilator
TOP        ?= tb_elevator
RTL_TOP    ?= elevator_controller
FILELIST   ?= tb.f
OBJ_DIR    ?= obj_dir
JOBS       ?= 0
VFLAGS     ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS ?= --lint-only -Wall
PASS_MSG   ?= === PASS ===

SOURCES     := $(shell cat $(FILELIST))
RTL_SOURCES := $(filter source/%,$(SOURCES))
SIM         := $(OBJ_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SOURCES)

clean:
	rm -rf $(OBJ_DIR)
